/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f \
		--top-module roce_eval_tb --Mdir obj_dir -o roce_eval_sim
	./obj_dir/roce_eval_sim +verilator+error+limit+100 | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/ack_matcher.sv */
`timescale 1ns/100ps
`include "roce_eval_defines.svh"

module ack_matcher (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run_start,
  input  logic                       rx_valid,
  input  logic                       head_valid,
  input  roce_eval_pkg::rx_ack_t     rx_ack,
  input  roce_eval_pkg::sent_entry_t head,
  input  logic [`ROCE_STAMP_W-1:0]   stamp,
  output logic                       pop,
  output logic                       ack_hit,
  output logic                       bad_frame,
  output roce_eval_pkg::ack_event_t  ack_event,
  output logic [`ROCE_STAMP_W-1:0]   latency_tot
);

  import roce_eval_pkg::*;

  logic judge;
  logic psn_ok;
  logic syn_ok;
  logic hit;

  // Only judged while something is outstanding and the run is still clean
  assign judge = rx_valid & head_valid & ~bad_frame;

  // Ack must name the oldest sent packet
  assign psn_ok = (rx_ack.psn == head.psn);
  // Type bits zero means plain ACK
  assign syn_ok = (rx_ack.syndrome[`ROCE_SYN_NAK_HI:`ROCE_SYN_NAK_LO] == 2'b00);

  assign hit = judge & psn_ok & syn_ok;

  // Pop in the same cycle so acks can come back to back
  assign pop     = hit;
  assign ack_hit = hit;

  // Event for the transfer timer, meaningful while ack_hit is high
  assign ack_event = ack_event_t'{
    psn:        head.psn,
    sent_stamp: head.stamp,
    ack_stamp:  stamp
  };

  // Latency sum and sticky error flag
  // cleared only by reset or a new run
  always_ff @(posedge clk) begin
    if (rst || run_start) begin
      latency_tot <= '0;
      bad_frame   <= 1'b0;
    end else if (judge) begin
      if (hit) begin
        // Edges between send and ack
        latency_tot <= latency_tot + (stamp - head.stamp);
      end else begin
        // Out of order psn or NAK, run is spoiled
        bad_frame <= 1'b1;
      end
    end
  end

endmodule

/* design/roce_eval_defines.svh */
`ifndef ROCE_EVAL_DEFINES_SVH
`define ROCE_EVAL_DEFINES_SVH

// Packet sequence number width from the BTH
`define ROCE_PSN_W 24

// Cycle stamp and every timing result
`define ROCE_STAMP_W 64

// Sent packet store, sized for a full window of outstanding writes
`define ROCE_FIFO_DEPTH 1024
// Log2 of the depth above
`define ROCE_FIFO_AW 10

// AETH syndrome type field
// 00 is ACK, anything else is RNR NAK or NAK
`define ROCE_SYN_NAK_HI 6
`define ROCE_SYN_NAK_LO 5

`endif

/* design/roce_eval_pkg.sv */
`include "roce_eval_defines.svh"

package roce_eval_pkg;

  // RC opcodes seen by the evaluator
  typedef enum logic [7:0] {
    RC_RDMA_WRITE_FIRST    = 8'h06,
    RC_RDMA_WRITE_MIDDLE   = 8'h07,
    RC_RDMA_WRITE_LAST     = 8'h08,
    RC_RDMA_WRITE_LAST_IMD = 8'h09,
    RC_RDMA_WRITE_ONLY     = 8'h0A,
    RC_RDMA_WRITE_ONLY_IMD = 8'h0B,
    RC_RDMA_ACK            = 8'h11
  } rc_opcode_e;

  // Transmit BTH fields of interest
  typedef struct packed {
    rc_opcode_e                op_code;
    logic [`ROCE_PSN_W-1:0]    psn;
  } tx_bth_t;

  // Received ack, BTH psn plus AETH syndrome
  typedef struct packed {
    logic [`ROCE_PSN_W-1:0]    psn;
    logic [7:0]                syndrome;
  } rx_ack_t;

  // One sent packet waiting for its ack
  typedef struct packed {
    logic [`ROCE_PSN_W-1:0]    psn;
    logic [`ROCE_STAMP_W-1:0]  stamp;
  } sent_entry_t;

  // Matched ack, with send time and ack time
  typedef struct packed {
    logic [`ROCE_PSN_W-1:0]    psn;
    logic [`ROCE_STAMP_W-1:0]  sent_stamp;
    logic [`ROCE_STAMP_W-1:0]  ack_stamp;
  } ack_event_t;

  typedef struct packed {
    logic [`ROCE_STAMP_W-1:0]  transfer_time_no_ack;
    logic [`ROCE_STAMP_W-1:0]  transfer_time;
    logic [`ROCE_STAMP_W-1:0]  latency_tot;
  } eval_results_t;

  // Opcodes that open a message
  function automatic logic is_msg_start(rc_opcode_e op);
    return op inside {RC_RDMA_WRITE_FIRST, RC_RDMA_WRITE_ONLY, RC_RDMA_WRITE_ONLY_IMD};
  endfunction

  // Opcodes that close a message; ONLY forms do both
  function automatic logic is_msg_end(rc_opcode_e op);
    return op inside {RC_RDMA_WRITE_LAST, RC_RDMA_WRITE_LAST_IMD,
                      RC_RDMA_WRITE_ONLY, RC_RDMA_WRITE_ONLY_IMD};
  endfunction

endpackage

/* design/roce_eval_top.sv */
`timescale 1ns/100ps
`include "roce_eval_defines.svh"

module roce_eval_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         start_i,
  input  logic                         tx_valid,
  input  roce_eval_pkg::tx_bth_t       tx_bth,
  input  logic                         rx_valid,
  input  roce_eval_pkg::rx_ack_t       rx_ack,
  output roce_eval_pkg::eval_results_t results,
  output logic                         bad_frame
);

  import roce_eval_pkg::*;

  // Run control
  logic                     run_start;
  logic [`ROCE_STAMP_W-1:0] stamp;

  // Sent store
  sent_entry_t              push_entry;
  sent_entry_t              head;
  logic                     head_valid;
  logic                     pop;

  // Ack path
  logic                     ack_hit;
  ack_event_t               ack_event;
  logic [`ROCE_STAMP_W-1:0] latency_tot;

  // Transfer results
  logic [`ROCE_STAMP_W-1:0] transfer_time;
  logic [`ROCE_STAMP_W-1:0] transfer_time_no_ack;

  run_timer i_run_timer (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start_i),
    .run_start (run_start),
    .stamp     (stamp)
  );

  // Every transmitted beat is stamped on the way in
  assign push_entry = sent_entry_t'{psn: tx_bth.psn, stamp: stamp};

  // Start edge empties the store
  sent_fifo i_sent_fifo (
    .clk        (clk),
    .rst        (rst),
    .flush      (run_start),
    .push       (tx_valid),
    .pop        (pop),
    .push_entry (push_entry),
    .head       (head),
    .head_valid (head_valid)
  );

  ack_matcher i_ack_matcher (
    .clk         (clk),
    .rst         (rst),
    .run_start   (run_start),
    .rx_valid    (rx_valid),
    .head_valid  (head_valid),
    .rx_ack      (rx_ack),
    .head        (head),
    .stamp       (stamp),
    .pop         (pop),
    .ack_hit     (ack_hit),
    .bad_frame   (bad_frame),
    .ack_event   (ack_event),
    .latency_tot (latency_tot)
  );

  transfer_timer i_transfer_timer (
    .clk                  (clk),
    .rst                  (rst),
    .run_start            (run_start),
    .tx_valid             (tx_valid),
    .ack_hit              (ack_hit),
    .tx_bth               (tx_bth),
    .ack_event            (ack_event),
    .transfer_time        (transfer_time),
    .transfer_time_no_ack (transfer_time_no_ack)
  );

  // Result bundle
  assign results = eval_results_t'{
    transfer_time_no_ack: transfer_time_no_ack,
    transfer_time:        transfer_time,
    latency_tot:          latency_tot
  };

endmodule

/* design/run_timer.sv */
`timescale 1ns/100ps
`include "roce_eval_defines.svh"

module run_timer (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start_i,
  output logic                     run_start,
  output logic [`ROCE_STAMP_W-1:0] stamp
);

  // Previous level of start_i
  logic start_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      start_d <= 1'b0;
    end else begin
      start_d <= start_i;
    end
  end

  // Rising edge, one cycle wide
  assign run_start = start_i & ~start_d;

  // Free-running stamp
  // zero one edge after the start pulse, counts edges from there
  always_ff @(posedge clk) begin
    if (rst || run_start) begin
      stamp <= '0;
    end else begin
      stamp <= stamp + 1'b1;
    end
  end

endmodule

/* design/sent_fifo.sv */
`timescale 1ns/100ps
`include "roce_eval_defines.svh"

module sent_fifo #(
  parameter int DEPTH = `ROCE_FIFO_DEPTH,
  parameter int AW    = `ROCE_FIFO_AW
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush,
  input  logic                       push,
  input  logic                       pop,
  input  roce_eval_pkg::sent_entry_t push_entry,
  output roce_eval_pkg::sent_entry_t head,
  output logic                       head_valid
);

  // Storage, no reset on the array
  roce_eval_pkg::sent_entry_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  // One extra bit so full is distinct from empty
  logic [AW:0]   count;
  logic          full;
  logic          do_push;
  logic          do_pop;

  assign full       = (count == (AW+1)'(DEPTH));
  assign head_valid = (count != '0);

  // Full store silently drops the new entry
  assign do_push = push & ~full;
  assign do_pop  = pop & head_valid;

  // Show-ahead read, oldest entry always on head
  assign head = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry;
    end
  end

  // Pointers wrap at DEPTH, so non power of two depths also work
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* design/transfer_timer.sv */
`timescale 1ns/100ps
`include "roce_eval_defines.svh"

module transfer_timer (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      run_start,
  input  logic                      tx_valid,
  input  logic                      ack_hit,
  input  roce_eval_pkg::tx_bth_t    tx_bth,
  input  roce_eval_pkg::ack_event_t ack_event,
  output logic [`ROCE_STAMP_W-1:0]  transfer_time,
  output logic [`ROCE_STAMP_W-1:0]  transfer_time_no_ack
);

  import roce_eval_pkg::*;

  // PSNs of the latest message boundaries on the wire
  logic [`ROCE_PSN_W-1:0]   start_psn;
  logic [`ROCE_PSN_W-1:0]   finish_psn;
  // Set once the matching psn above has been captured in this run
  logic                     start_seen;
  logic                     finish_seen;
  // Send stamp of the acked first packet
  logic [`ROCE_STAMP_W-1:0] begin_stamp;

  logic                     tx_start;
  logic                     tx_end;
  logic                     start_match;
  logic                     finish_match;
  logic [`ROCE_STAMP_W-1:0] begin_eff;

  // Message boundaries from the transmit opcode
  assign tx_start = tx_valid & is_msg_start(tx_bth.op_code);
  assign tx_end   = tx_valid & is_msg_end(tx_bth.op_code);

  // Ack of the first or last packet of the tracked message
  assign start_match  = ack_hit & start_seen & (ack_event.psn == start_psn);
  assign finish_match = ack_hit & finish_seen & (ack_event.psn == finish_psn);

  // ONLY messages open and close in one event
  assign begin_eff = start_match ? ack_event.sent_stamp : begin_stamp;

  always_ff @(posedge clk) begin
    if (tx_start) begin
      start_psn <= tx_bth.psn;
    end
    if (tx_end) begin
      finish_psn <= tx_bth.psn;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || run_start) begin
      start_seen           <= 1'b0;
      finish_seen          <= 1'b0;
      begin_stamp          <= '0;
      transfer_time        <= '0;
      transfer_time_no_ack <= '0;
    end else begin
      if (tx_start) begin
        start_seen <= 1'b1;
      end
      if (tx_end) begin
        finish_seen <= 1'b1;
      end
      if (start_match) begin
        begin_stamp <= ack_event.sent_stamp;
      end
      if (finish_match) begin
        // First send to last ack
        transfer_time        <= ack_event.ack_stamp - begin_eff;
        // First send to last send
        transfer_time_no_ack <= ack_event.sent_stamp - begin_eff;
      end
    end
  end

endmodule

/* files.f */
+incdir+design
design/roce_eval_pkg.sv
design/run_timer.sv
design/sent_fifo.sv
design/ack_matcher.sv
design/transfer_timer.sv
design/roce_eval_top.sv
tests/roce_eval_sva.sv
tests/roce_eval_tb.sv

/* tests/roce_eval_sva.sv */
`timescale 1ns/100ps
`include "roce_eval_defines.svh"

module roce_eval_sva (
  input logic                     clk,
  input logic                     rst,
  input logic                     run_start,
  input logic                     bad_frame,
  input logic                     pop,
  input logic                     head_valid,
  input logic [`ROCE_STAMP_W-1:0] latency_tot
);

  // Failed assertions so far for the testbench summary
  int fail_count = 0;

  // Error flag holds until a new run begins
  bad_sticky: assert property (
    @(posedge clk) disable iff (rst)
      (bad_frame && !run_start) |=> bad_frame
  ) else begin
    fail_count++;
    $error("bad_frame fell without a run start");
  end

  // Latency sum only grows inside a run
  latency_monotonic: assert property (
    @(posedge clk) disable iff (rst)
      !run_start |=> (latency_tot >= $past(latency_tot))
  ) else begin
    fail_count++;
    $error("latency_tot decreased inside a run");
  end

  // Head entry was sent at least one edge before its ack
  // so every pop adds a nonzero latency
  pop_adds_latency: assert property (
    @(posedge clk) disable iff (rst)
      (pop && !run_start) |=> (latency_tot > $past(latency_tot))
  ) else begin
    fail_count++;
    $error("accepted ack added no latency");
  end

endmodule

bind roce_eval_top roce_eval_sva i_roce_eval_sva (
  .clk         (clk),
  .rst         (rst),
  .run_start   (run_start),
  .bad_frame   (bad_frame),
  .pop         (pop),
  .head_valid  (head_valid),
  .latency_tot (latency_tot)
);

/* tests/roce_eval_tb.sv */
`timescale 1ns/100ps
`include "roce_eval_defines.svh"

module roce_eval_tb;

  import roce_eval_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int MAX_GAP    = 3;
  localparam int RAND_RUNS  = 10;
  // Upper bounds in cycles for each test
  localparam int T1_CYCLES    = 20;
  localparam int T2_CYCLES    = 80;
  localparam int T3_CYCLES    = 60;
  localparam int T4_CYCLES    = 60;
  localparam int T5_CYCLES    = 80;
  localparam int T6_CYCLES    = RAND_RUNS * 200;
  localparam int TOTAL_CYCLES = T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                              + T5_CYCLES + T6_CYCLES;

  // One sampled beat, tx or ack, with the stamp it saw
  typedef struct packed {
    logic                     is_tx;
    logic [7:0]               op;
    logic [`ROCE_PSN_W-1:0]   psn;
    logic [7:0]               syndrome;
    logic [`ROCE_STAMP_W-1:0] stamp;
  } log_rec_t;

  logic          clk;
  logic          rst;
  logic          start_i;
  logic          tx_valid;
  tx_bth_t       tx_bth;
  logic          rx_valid;
  rx_ack_t       rx_ack;
  eval_results_t results;
  logic          bad_frame;

  // Model side
  log_rec_t                 ev_log [$];
  logic [`ROCE_STAMP_W-1:0] stamp_m;
  logic                     start_prev;
  eval_results_t            exp_res;
  logic                     exp_bad;
  // Stimulus side
  logic [`ROCE_PSN_W-1:0]   outstanding [$];
  logic [`ROCE_PSN_W-1:0]   next_psn;
  int                       checks = 0;
  int                       errors = 0;
  int                       test_err_base = 0;

  roce_eval_top i_roce_eval_top (
    .clk       (clk),
    .rst       (rst),
    .start_i   (start_i),
    .tx_valid  (tx_valid),
    .tx_bth    (tx_bth),
    .rx_valid  (rx_valid),
    .rx_ack    (rx_ack),
    .results   (results),
    .bad_frame (bad_frame)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Stamp mirror and event log, inputs as the DUT samples them
  always @(posedge clk) begin
    if (rst) begin
      stamp_m = '0;
      ev_log.delete();
    end else if (start_i && !start_prev) begin
      // New run, stamp reads zero after this edge
      stamp_m = '0;
      ev_log.delete();
    end else begin
      // Acks first, a same-edge push is not yet on the head
      if (rx_valid) begin
        ev_log.push_back(log_rec_t'{is_tx: 1'b0, op: 8'h00, psn: rx_ack.psn,
                                    syndrome: rx_ack.syndrome, stamp: stamp_m});
      end
      if (tx_valid) begin
        ev_log.push_back(log_rec_t'{is_tx: 1'b1, op: tx_bth.op_code, psn: tx_bth.psn,
                                    syndrome: 8'h00, stamp: stamp_m});
      end
      stamp_m = stamp_m + 64'd1;
    end
    start_prev = rst ? 1'b0 : start_i;
  end

  // Expected results from the whole log of the current run
  function automatic eval_results_t reference_results(output logic bad);
    log_rec_t                 pend [$];
    log_rec_t                 head;
    logic [`ROCE_PSN_W-1:0]   start_psn;
    logic [`ROCE_PSN_W-1:0]   finish_psn;
    logic                     start_seen;
    logic                     finish_seen;
    logic                     start_hit;
    logic                     finish_hit;
    logic [`ROCE_STAMP_W-1:0] begin_stamp;
    logic [`ROCE_STAMP_W-1:0] begin_eff;
    eval_results_t            r;
    bad         = 1'b0;
    r           = '0;
    start_psn   = '0;
    finish_psn  = '0;
    start_seen  = 1'b0;
    finish_seen = 1'b0;
    begin_stamp = '0;
    foreach (ev_log[i]) begin
      if (ev_log[i].is_tx) begin
        pend.push_back(ev_log[i]);
        // FIRST, ONLY and ONLY with immediate open a message
        if (ev_log[i].op inside {8'h06, 8'h0A, 8'h0B}) begin
          start_psn  = ev_log[i].psn;
          start_seen = 1'b1;
        end
        // LAST, LAST with immediate and both ONLY forms close one
        if (ev_log[i].op inside {8'h08, 8'h09, 8'h0A, 8'h0B}) begin
          finish_psn  = ev_log[i].psn;
          finish_seen = 1'b1;
        end
      end else if (pend.size() != 0 && !bad) begin
        head = pend[0];
        if (ev_log[i].psn == head.psn && ev_log[i].syndrome[6:5] == 2'b00) begin
          pend.delete(0);
          r.latency_tot = r.latency_tot + (ev_log[i].stamp - head.stamp);
          start_hit  = start_seen && (head.psn == start_psn);
          finish_hit = finish_seen && (head.psn == finish_psn);
          begin_eff  = start_hit ? head.stamp : begin_stamp;
          if (start_hit) begin
            begin_stamp = head.stamp;
          end
          if (finish_hit) begin
            r.transfer_time        = ev_log[i].stamp - begin_eff;
            r.transfer_time_no_ack = head.stamp - begin_eff;
          end
        end else begin
          bad = 1'b1;
        end
      end
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      exp_res = reference_results(exp_bad);
      check_value("latency_tot", results.latency_tot, exp_res.latency_tot);
      check_value("transfer_time", results.transfer_time, exp_res.transfer_time);
      check_value("transfer_time_no_ack", results.transfer_time_no_ack,
                  exp_res.transfer_time_no_ack);
      check_value("bad_frame", 64'(bad_frame), 64'(exp_bad));
    end
  end

  // All stimulus tasks are entered just after a rising edge
  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic pulse_start();
    start_i <= 1'b1;
    @(posedge clk);
    start_i <= 1'b0;
    @(posedge clk);
    outstanding.delete();
  endtask

  task automatic send_pkt(input rc_opcode_e op, input logic [`ROCE_PSN_W-1:0] psn);
    tx_valid <= 1'b1;
    tx_bth   <= tx_bth_t'{op_code: op, psn: psn};
    outstanding.push_back(psn);
    @(posedge clk);
    tx_valid <= 1'b0;
  endtask

  task automatic send_ack(input logic [`ROCE_PSN_W-1:0] psn, input logic [7:0] syn);
    rx_valid <= 1'b1;
    rx_ack   <= rx_ack_t'{psn: psn, syndrome: syn};
    @(posedge clk);
    rx_valid <= 1'b0;
  endtask

  // Plain ACK and NAK syndromes, credit bits random
  function automatic logic [7:0] good_syndrome();
    return {3'b000, 5'($urandom_range(0, 31))};
  endfunction

  function automatic logic [7:0] nak_syndrome();
    return {3'b011, 5'($urandom_range(0, 31))};
  endfunction

  // One message of len packets, random gap after each
  task automatic send_msg(input int len);
    rc_opcode_e op;
    for (int i = 0; i < len; i++) begin
      if (len == 1) begin
        op = ($urandom_range(0, 1) != 0) ? RC_RDMA_WRITE_ONLY_IMD : RC_RDMA_WRITE_ONLY;
      end else if (i == 0) begin
        op = RC_RDMA_WRITE_FIRST;
      end else if (i == len - 1) begin
        op = ($urandom_range(0, 1) != 0) ? RC_RDMA_WRITE_LAST_IMD : RC_RDMA_WRITE_LAST;
      end else begin
        op = RC_RDMA_WRITE_MIDDLE;
      end
      send_pkt(op, next_psn);
      next_psn = next_psn + 1'b1;
      idle(int'($urandom_range(0, MAX_GAP)));
    end
  endtask

  // Ack everything outstanding, oldest first
  task automatic ack_all();
    while (outstanding.size() != 0) begin
      send_ack(outstanding.pop_front(), good_syndrome());
      idle(int'($urandom_range(0, MAX_GAP)));
    end
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d mismatches", name, errors - test_err_base);
    test_err_base = errors;
  endtask

  initial begin
    int n_msgs;
    void'($urandom(32'h90b89b2a));
    rst      = 1'b1;
    start_i  = 1'b0;
    tx_valid = 1'b0;
    tx_bth   = '0;
    rx_valid = 1'b0;
    rx_ack   = '0;
    next_psn = 24'h000100;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    pulse_start();
    idle(4);
    end_test("T1 reset and start");

    // Several ONLY messages, then acks in order
    pulse_start();
    repeat (6) send_msg(1);
    ack_all();
    idle(2);
    end_test("T2 only messages");

    pulse_start();
    send_msg(4);
    ack_all();
    idle(2);
    end_test("T3 multi packet message");

    // Good ack, then a NAK, later acks must not count
    pulse_start();
    repeat (3) send_msg(1);
    send_ack(outstanding.pop_front(), good_syndrome());
    idle(1);
    send_ack(outstanding.pop_front(), nak_syndrome());
    ack_all();
    idle(2);
    end_test("T4 nak syndrome");

    // Wrong psn spoils the run, restart must recover
    pulse_start();
    repeat (2) send_msg(1);
    send_ack(outstanding[0] + 24'd3, good_syndrome());
    idle(2);
    pulse_start();
    send_msg(2);
    send_msg(1);
    ack_all();
    idle(2);
    end_test("T5 wrong psn and restart");

    // Random lengths, ack points and psn bases, wrap included
    for (int run = 0; run < RAND_RUNS; run++) begin
      pulse_start();
      next_psn = 24'($urandom());
      n_msgs   = int'($urandom_range(1, 5));
      for (int m = 0; m < n_msgs; m++) begin
        send_msg(int'($urandom_range(1, 4)));
        if ($urandom_range(0, 1) != 0) begin
          ack_all();
        end
      end
      ack_all();
      idle(2);
    end
    end_test("T6 random runs");

    $display("Summary: %0d checks, %0d mismatches, %0d assertion failures", checks, errors,
             i_roce_eval_top.i_roce_eval_sva.fail_count);
    if (errors == 0 && i_roce_eval_top.i_roce_eval_sva.fail_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog, twice the summed test budgets
  initial begin
    #(TOTAL_CYCLES * CLK_PERIOD * 2);
    $display("Timeout: stimulus did not finish within %0d cycles", TOTAL_CYCLES * 2);
    $display("test failed");
    $finish;
  end

endmodule
